// File: Bender.yml
package:
  name: codec_ilv_buffer

sources:
  - include_dirs:
      - logic
    files:
      - logic/frame_pkg.sv
      - logic/bank_pkg.sv
      - logic/frame_writer.sv
      - logic/buffer_bank_ctrl.sv
      - logic/bank_ram.sv
      - logic/ilv_reader.sv
      - logic/codec_ilv_buffer.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_codec_ilv_buffer.sv

// File: build.f
+incdir+logic
logic/frame_pkg.sv
logic/bank_pkg.sv
logic/frame_writer.sv
logic/buffer_bank_ctrl.sv
logic/bank_ram.sv
logic/ilv_reader.sv
logic/codec_ilv_buffer.sv
tests/tb_codec_ilv_buffer.sv

// File: logic/bank_pkg.sv
`default_nettype none

`include "codec_buffer_consts.svh"

// storage side of the codec buffer
// bank pointers, word slots and reader counters

package bank_pkg;

  //--------------------------------------------------------------------
  // bank pointers and addressing
  //--------------------------------------------------------------------

  typedef logic [`BNUM_W-1 : 0]  bank_t;   // bank index
  typedef logic [`WADDR_W-1 : 0] waddr_t;  // word slot inside one bank

  //--------------------------------------------------------------------
  // transpose counters
  //--------------------------------------------------------------------

  // reader walks rows inside a column
  typedef logic [$clog2(`ILV_ROWS)-1 : 0] row_t;

  // outer loop of the reader
  typedef logic [$clog2(`ILV_COLS)-1 : 0] col_t;

endpackage

`default_nettype wire

// File: logic/bank_ram.sv
`default_nettype none

// simple dual port ram, one write port and one read port
// read data shows up the cycle after re

module bank_ram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                       iclk,
  // write side
  input  logic                       we,
  input  logic [$clog2(DEPTH)-1 : 0] waddr,
  input  payload_t                   wdata,
  // read side
  input  logic                       re,
  input  logic [$clog2(DEPTH)-1 : 0] raddr,
  output payload_t                   rdata
);

  //--------------------------------------------------------------------
  // storage
  //--------------------------------------------------------------------

  payload_t mem [DEPTH];

  always_ff @(posedge iclk) begin
    if (we)
      mem[waddr] <= wdata;
  end

  //--------------------------------------------------------------------
  // registered read
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (re)
      rdata <= mem[raddr];   // old data on same-address collision
  end

endmodule

`default_nettype wire

// File: logic/buffer_bank_ctrl.sv
`default_nettype none

`include "codec_buffer_consts.svh"

module buffer_bank_ctrl
  import bank_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  //
  input  logic  wfull,        // writer finished bank at wbank
  output bank_t wbank,        // bank being filled
  //
  input  logic  rempty,       // reader released bank at rbank
  output bank_t rbank,        // bank being drained
  //
  output logic  ready,        // some bank holds a full frame
  output logic  oempty_all,   // every bank free
  output logic  ofull_all     // every bank occupied
);

  //--------------------------------------------------------------------
  // state
  //--------------------------------------------------------------------

  localparam int BNUM = 2**`BNUM_W;

  logic [BNUM-1 : 0] busy;       // one flag per bank
  bank_t             wbank_r;
  bank_t             rbank_r;
  bank_t             wbank_nxt;  // bank after the write pointer

  logic              wswitch;
  logic              rswitch;

  assign wbank_nxt = wbank_r + 1'b1;  // wraps over the bank ring

  // move on only if the next bank is free or the stuck bank drains
  assign wswitch = (wfull & rempty) |
                   (wfull & ~busy[wbank_nxt]) |
                   (rempty & busy[wbank_r]);

  // move on only when a full bank gets released
  assign rswitch = (wfull & rempty) | (rempty & busy[rbank_r]);

  //--------------------------------------------------------------------
  // busy flags and pointers
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy    <= '0;
      wbank_r <= '0;
      rbank_r <= '0;
    end
    else begin
      for (int i = 0; i < BNUM; i++) begin
        if (wfull & (wbank_r == bank_t'(i)))
          busy[i] <= 1'b1;                  // set wins over clear
        else if (rempty & (rbank_r == bank_t'(i)))
          busy[i] <= 1'b0;
      end
      if (wswitch)
        wbank_r <= wbank_nxt;
      if (rswitch)
        rbank_r <= rbank_r + 1'b1;
    end
  end

  assign wbank      = wbank_r;
  assign rbank      = rbank_r;

  // in-order fill and drain, so any busy bank means rbank is full
  assign ready      = |busy;
  assign oempty_all = ~|busy;
  assign ofull_all  = &busy;

endmodule

`default_nettype wire

// File: logic/codec_buffer_consts.svh
`ifndef CODEC_BUFFER_CONSTS_SVH
`define CODEC_BUFFER_CONSTS_SVH

//----------------------------------------------------------------------
// bank geometry
//----------------------------------------------------------------------

`define BNUM_W     2                            // 4 banks
`define ILV_ROWS   4                            // rows per frame
`define ILV_COLS   6                            // columns per frame
`define FRAME_LEN  (`ILV_ROWS * `ILV_COLS)      // 24 words

//----------------------------------------------------------------------
// payload and address widths
//----------------------------------------------------------------------

`define SAMPLE_W   8
`define TAG_W      4

// must cover FRAME_LEN word slots
`define WADDR_W    5

`endif

// File: logic/codec_ilv_buffer.sv
`default_nettype none

`include "codec_buffer_consts.svh"

module codec_ilv_buffer
  import frame_pkg::*, bank_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  // input frames, row by row
  input  logic    isop,
  input  logic    ival,
  input  sample_t idat,
  input  tag_t    itag,
  // output frames, column by column
  output logic    oval,
  output logic    osop,
  output logic    oeop,
  output sample_t odat,
  output tag_t    otag,
  // bank status
  output logic    oempty_all,
  output logic    ofull_all
);

  //--------------------------------------------------------------------
  // ram sizes
  //--------------------------------------------------------------------

  // each bank owns a power-of-two window so {bank, word} is the address
  localparam int SMP_DEPTH = 1 << (`BNUM_W + `WADDR_W);
  localparam int TAG_DEPTH = 1 << `BNUM_W;   // one label per bank

  //--------------------------------------------------------------------
  // internal wires
  //--------------------------------------------------------------------

  bank_t   wbank;
  bank_t   rbank;
  logic    wfull;
  logic    rempty;
  logic    ready;

  logic    wr_en;
  bank_t   wr_bank;
  waddr_t  wr_addr;
  sample_t wr_data;
  logic    tag_we;
  tag_t    tag_data;

  logic    rd_en;
  bank_t   rd_bank;
  waddr_t  rd_addr;
  sample_t rd_sample;
  tag_t    rd_tag;

  //--------------------------------------------------------------------
  // writer stage
  //--------------------------------------------------------------------

  frame_writer u_writer (
    .iclk     (iclk),
    .ireset   (ireset),
    .ival     (ival),
    .isop     (isop),
    .idat     (idat),
    .itag     (itag),
    .wbank    (wbank),
    .wr_en    (wr_en),
    .wr_bank  (wr_bank),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .tag_we   (tag_we),
    .tag_data (tag_data),
    .wfull    (wfull)
  );

  //--------------------------------------------------------------------
  // banked storage and its pointers
  //--------------------------------------------------------------------

  buffer_bank_ctrl u_ctrl (
    .iclk       (iclk),
    .ireset     (ireset),
    .wfull      (wfull),
    .wbank      (wbank),
    .rempty     (rempty),
    .rbank      (rbank),
    .ready      (ready),
    .oempty_all (oempty_all),
    .ofull_all  (ofull_all)
  );

  bank_ram #(
    .payload_t (sample_t),
    .DEPTH     (SMP_DEPTH)
  ) u_sample_ram (
    .iclk  (iclk),
    .we    (wr_en),
    .waddr ({wr_bank, wr_addr}),
    .wdata (wr_data),
    .re    (rd_en),
    .raddr ({rd_bank, rd_addr}),
    .rdata (rd_sample)
  );

  bank_ram #(
    .payload_t (tag_t),
    .DEPTH     (TAG_DEPTH)
  ) u_tag_ram (
    .iclk  (iclk),
    .we    (tag_we),
    .waddr (wr_bank),
    .wdata (tag_data),
    .re    (rd_en),
    .raddr (rd_bank),
    .rdata (rd_tag)
  );

  //--------------------------------------------------------------------
  // interleaving reader
  //--------------------------------------------------------------------

  ilv_reader u_reader (
    .iclk      (iclk),
    .ireset    (ireset),
    .ready     (ready),
    .rbank     (rbank),
    .rempty    (rempty),
    .rd_en     (rd_en),
    .rd_bank   (rd_bank),
    .rd_addr   (rd_addr),
    .rd_sample (rd_sample),
    .rd_tag    (rd_tag),
    .oval      (oval),
    .osop      (osop),
    .oeop      (oeop),
    .odat      (odat),
    .otag      (otag)
  );

endmodule

`default_nettype wire

// File: logic/frame_pkg.sv
`default_nettype none

`include "codec_buffer_consts.svh"

// payload side of the codec buffer
// what flows in and out with every word and every frame

package frame_pkg;

  //--------------------------------------------------------------------
  // data word
  //--------------------------------------------------------------------

  // one channel sample, one per strobe
  typedef logic [`SAMPLE_W-1 : 0] sample_t;

  //--------------------------------------------------------------------
  // frame label
  //--------------------------------------------------------------------

  // taken with isop, comes back out with osop
  typedef logic [`TAG_W-1 : 0] tag_t;

endpackage

`default_nettype wire

// File: logic/frame_writer.sv
`default_nettype none

`include "codec_buffer_consts.svh"

module frame_writer
  import frame_pkg::*, bank_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  // input stream
  input  logic    ival,       // one strobe per word
  input  logic    isop,       // first word of frame
  input  sample_t idat,
  input  tag_t    itag,       // valid with isop
  // bank pointer from controller
  input  bank_t   wbank,
  // sample ram write port
  output logic    wr_en,
  output bank_t   wr_bank,
  output waddr_t  wr_addr,
  output sample_t wr_data,
  // tag ram write port
  output logic    tag_we,
  output tag_t    tag_data,
  // bank done, to controller
  output logic    wfull
);

  //--------------------------------------------------------------------
  // word slot tracking
  //--------------------------------------------------------------------

  localparam waddr_t LAST_ADDR = waddr_t'(`FRAME_LEN - 1);

  waddr_t addr_cnt;   // slot for the next strobe
  waddr_t cur_addr;   // slot for the strobe on the bus now
  logic   cur_last;

  assign cur_addr = isop ? '0 : addr_cnt;   // sop restarts the frame
  assign cur_last = (cur_addr == LAST_ADDR);

  //--------------------------------------------------------------------
  // control regs
  //--------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      addr_cnt <= '0;
      wr_en    <= 1'b0;
      tag_we   <= 1'b0;
      wfull    <= 1'b0;
    end
    else begin
      wr_en  <= ival;
      tag_we <= ival & isop;      // tag written once per frame
      wfull  <= ival & cur_last;  // lines up with the last word write
      if (ival) begin
        if (cur_last)
          addr_cnt <= '0;         // wrap for next frame
        else
          addr_cnt <= cur_addr + 1'b1;
      end
    end
  end

  //--------------------------------------------------------------------
  // payload regs
  //--------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (ival) begin
      wr_addr <= cur_addr;
      wr_data <= idat;
    end
    if (ival & isop)
      tag_data <= itag;
  end

  // wbank only moves after wfull, so it holds for the whole fill
  assign wr_bank = wbank;

endmodule

`default_nettype wire

// File: logic/ilv_reader.sv
`default_nettype none

`include "codec_buffer_consts.svh"

module ilv_reader
  import frame_pkg::*, bank_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  // controller side
  input  logic    ready,       // full bank waiting at rbank
  input  bank_t   rbank,
  output logic    rempty,      // pulse on last address issued
  // ram read port
  output logic    rd_en,
  output bank_t   rd_bank,
  output waddr_t  rd_addr,
  input  sample_t rd_sample,   // one cycle after rd_en
  input  tag_t    rd_tag,
  // output stream
  output logic    oval,
  output logic    osop,
  output logic    oeop,
  output sample_t odat,
  output tag_t    otag
);

  //--------------------------------------------------------------------
  // address generation
  //--------------------------------------------------------------------

  typedef enum logic {
    ST_IDLE,
    ST_READ
  } state_t;

  localparam row_t   LAST_ROW = row_t'(`ILV_ROWS - 1);
  localparam col_t   LAST_COL = col_t'(`ILV_COLS - 1);
  localparam waddr_t ROW_STEP = waddr_t'(`ILV_COLS);   // one row down

  state_t state;
  row_t   row;
  col_t   col;
  waddr_t addr;       // row * ILV_COLS + col, kept incrementally
  logic   first;      // first address of the frame
  logic   last;       // last address of the frame

  assign first  = (state == ST_READ) & (row == '0) & (col == '0);
  assign last   = (state == ST_READ) & (row == LAST_ROW) & (col == LAST_COL);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= ST_IDLE;
      row   <= '0;
      col   <= '0;
      addr  <= '0;
    end
    else begin
      case (state)
        ST_IDLE : begin
          row  <= '0;
          col  <= '0;
          addr <= '0;
          if (ready)
            state <= ST_READ;
        end
        ST_READ : begin
          if (row == LAST_ROW) begin         // column done
            row  <= '0;
            col  <= col + 1'b1;
            addr <= waddr_t'(col) + 1'b1;    // top of next column
            if (col == LAST_COL)
              state <= ST_IDLE;              // bank released, rest a cycle
          end
          else begin
            row  <= row + 1'b1;
            addr <= addr + ROW_STEP;
          end
        end
        default : state <= ST_IDLE;
      endcase
    end
  end

  assign rd_en   = (state == ST_READ);
  assign rd_addr = addr;
  assign rd_bank = rbank;   // steady until the edge after rempty
  assign rempty  = last;

  //--------------------------------------------------------------------
  // output pipe, markers follow the data through ram and out reg
  //--------------------------------------------------------------------

  logic s1_val;
  logic s1_sop;
  logic s1_eop;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val <= 1'b0;
      s1_sop <= 1'b0;
      s1_eop <= 1'b0;
      oval   <= 1'b0;
      osop   <= 1'b0;
      oeop   <= 1'b0;
    end
    else begin
      s1_val <= rd_en;   // ram stage
      s1_sop <= first;
      s1_eop <= last;
      oval   <= s1_val;  // out reg stage
      osop   <= s1_sop;
      oeop   <= s1_eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (s1_val)
      odat <= rd_sample;
    if (s1_sop)
      otag <= rd_tag;    // hold label for the whole frame
  end

endmodule

`default_nettype wire

// File: tests/tb_codec_ilv_buffer.sv
`default_nettype none

`include "codec_buffer_consts.svh"

module tb_codec_ilv_buffer
  import frame_pkg::*;
();

  //--------------------------------------------------------------------
  // run setup
  //--------------------------------------------------------------------

  localparam int NUM_FRAMES    = 40;
  localparam int DRAIN_TIMEOUT = 20000;   // cycles far beyond 40 frames

  logic    iclk;
  logic    ireset;
  logic    isop;
  logic    ival;
  sample_t idat;
  tag_t    itag;
  logic    oval;
  logic    osop;
  logic    oeop;
  sample_t odat;
  tag_t    otag;
  logic    oempty_all;
  logic    ofull_all;

  integer  seed;
  int      out_cnt;        // word index inside the current output frame
  int      frames_out;     // complete frames seen at the output

  // reference model of transposed words and tags in input order
  sample_t exp_words[$];
  tag_t    exp_tags[$];

  codec_ilv_buffer u_dut (
    .iclk       (iclk),
    .ireset     (ireset),
    .isop       (isop),
    .ival       (ival),
    .idat       (idat),
    .itag       (itag),
    .oval       (oval),
    .osop       (osop),
    .oeop       (oeop),
    .odat       (odat),
    .otag       (otag),
    .oempty_all (oempty_all),
    .ofull_all  (ofull_all)
  );

  always #20 iclk = ~iclk;   // period 40

  //--------------------------------------------------------------------
  // reporting
  //--------------------------------------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      stop_with_failure("value mismatch at the DUT output");
    end
  endtask

  //--------------------------------------------------------------------
  // stimulus driven on the falling edge
  //--------------------------------------------------------------------

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge iclk);
      ival = 1'b0;
      isop = 1'b0;
      idat = '0;
      itag = '0;
    end
  endtask

  // sends one frame row by row and queues it column by column
  task automatic send_frame(input bit burst);
    sample_t frame [`FRAME_LEN];
    tag_t    tag;
    int      gap;
    tag = tag_t'($random(seed));
    for (int i = 0; i < `FRAME_LEN; i++)
      frame[i] = sample_t'($random(seed));
    for (int c = 0; c < `ILV_COLS; c++)
      for (int r = 0; r < `ILV_ROWS; r++)
        exp_words.push_back(frame[r * `ILV_COLS + c]);
    exp_tags.push_back(tag);
    for (int i = 0; i < `FRAME_LEN; i++) begin
      if (!burst && i > 0) begin
        gap = {$random(seed)} % 3;   // holes inside the frame
        idle_cycles(gap);
      end
      @(negedge iclk);
      ival = 1'b1;
      isop = (i == 0);
      idat = frame[i];
      // junk tag off sop never reaches otag
      itag = (i == 0) ? tag : tag_t'($random(seed));
    end
    // at least 4 idle cycles before the next frame
    gap = burst ? 4 : 4 + ({$random(seed)} % 9);
    idle_cycles(gap);
  endtask

  //--------------------------------------------------------------------
  // output monitor sampled on the falling edge
  //--------------------------------------------------------------------

  always @(negedge iclk) begin
    if (!ireset) begin
      if (oval) begin
        if (out_cnt == 0) begin
          check_value("osop", osop, 1);
          if (exp_tags.size() == 0)
            stop_with_failure("output frame started with no input frame pending");
          else
            check_value("otag", otag, exp_tags.pop_front());
          check_value("oempty_all", oempty_all, 0);   // bank still held
        end
        else begin
          check_value("osop", osop, 0);
        end
        if (exp_words.size() == 0)
          stop_with_failure("output word arrived with no word in the model");
        else
          check_value("odat", odat, exp_words.pop_front());
        check_value("oeop", oeop, out_cnt == `FRAME_LEN - 1);
        if (out_cnt == `FRAME_LEN - 1) begin
          out_cnt = 0;
          frames_out++;
        end
        else begin
          out_cnt++;
        end
      end
      else begin
        check_value("osop", osop, 0);   // markers only ride on strobes
        check_value("oeop", oeop, 0);
        if (out_cnt != 0)
          stop_with_failure("oval dropped in the middle of an output frame");
      end
    end
  end

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------

  initial begin
    int  waited;
    bit  burst;
    iclk        = 1'b0;
    ireset      = 1'b1;
    isop        = 1'b0;
    ival        = 1'b0;
    idat        = '0;
    itag        = '0;
    seed        = 32'h9e3a_3b4e;
    out_cnt     = 0;
    frames_out  = 0;
    waited      = 0;

    // reset over 3 rising edges
    repeat (3) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;

    // state right after reset
    check_value("oempty_all", oempty_all, 1);
    check_value("ofull_all", ofull_all, 0);
    check_value("oval", oval, 0);

    idle_cycles(4);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      // two runs at the minimum gap keep several banks in flight
      burst = (f >= 10 && f < 14) || (f >= 25 && f < 29);
      send_frame(burst);
    end

    // drain with a bound
    while (frames_out < NUM_FRAMES) begin
      @(posedge iclk);
      waited++;
      if (waited > DRAIN_TIMEOUT)
        stop_with_failure("timed out waiting for all output frames");
    end

    repeat (3) @(negedge iclk);
    check_value("oempty_all", oempty_all, 1);
    check_value("ofull_all", ofull_all, 0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
